/* Bender.yml */
package:
  name: link_master_kernel

sources:
  - src/link_pkg.sv
  - src/link_credit_counter.sv
  - src/link_calib_sequencer.sv
  - src/link_calib_checker.sv
  - src/link_channel_out.sv
  - src/link_master_kernel.sv
  - target: test
    files:
      - verification/link_master_kernel_asserts.sv
      - verification/link_master_kernel_tb.sv

/* sources.f */
src/link_pkg.sv
src/link_credit_counter.sv
src/link_calib_sequencer.sv
src/link_calib_checker.sv
src/link_channel_out.sv
src/link_master_kernel.sv
verification/link_master_kernel_asserts.sv
verification/link_master_kernel_tb.sv

/* src/link_calib_checker.sv */
// per-channel calibration scoring against the returned loopback word
// the channel goes active only when every test passed

module link_calib_checker (
  input  logic                  io_master_clk_i,
  input  logic                  reset_i,
  input  logic                  sample_i,
  input  logic                  calib_done_i,
  input  logic                  io_valid_i,
  input  link_pkg::calib_word_u io_word_i,
  input  link_pkg::test_index_t test_index_i,
  output logic                  channel_active_o
);

  localparam link_pkg::test_index_t last_test_lp =
    link_pkg::test_index_t'(link_pkg::number_tests_c - 1);

  logic [link_pkg::calib_pattern_width_c-1:0] expect_pattern_w;
  logic hit_w;
  logic done_n;
  logic [link_pkg::number_tests_c-1:0] pass_r, pass_n;
  logic active_r;

  // ----------------------------------------
  // compare in the calibration view
  // ----------------------------------------

  assign expect_pattern_w = test_index_i[0] ? link_pkg::calib_pattern_odd_c :
                                              link_pkg::calib_pattern_even_c;

  // missing valid counts as a fail
  assign hit_w = io_valid_i
              && (io_word_i.calib_view.tag == test_index_i)
              && (io_word_i.calib_view.pattern == expect_pattern_w);

  always_comb begin
    pass_n = pass_r;
    if (sample_i) begin
      pass_n[test_index_i] = hit_w;
    end
    // last sample counts as done so active rises with calib_done
    done_n = calib_done_i || (sample_i && (test_index_i == last_test_lp));
  end

  // ----------------------------------------
  // score and activation
  // ----------------------------------------

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      pass_r <= '0;
      active_r <= 1'b0;
    end else begin
      pass_r <= pass_n;
      active_r <= done_n && (&pass_n);
    end
  end

  assign channel_active_o = active_r;

endmodule

/* src/link_calib_sequencer.sv */
// calibration phase sequencer, one instance drives every channel
// needs lg_wait_after_reset_p >= 1 and hold_cycles_p >= 2 for the loopback to settle

module link_calib_sequencer #(
  parameter int lg_wait_after_reset_p = 4,
  parameter int prepare_cycles_p = 6,
  parameter int hold_cycles_p = 4
) (
  input  logic                  io_master_clk_i,
  input  logic                  reset_i,
  output logic                  slave_reset_o,
  output logic                  calib_hold_o,
  output logic                  sample_o,
  output logic                  calib_done_o,
  output link_pkg::test_index_t test_index_o
);

  // one counter covers the wait and both phase lengths
  localparam int phase_max_lp = (prepare_cycles_p > hold_cycles_p) ?
                                prepare_cycles_p : hold_cycles_p;
  localparam int phase_bits_lp = $clog2(phase_max_lp);
  localparam int count_width_lp = (lg_wait_after_reset_p > phase_bits_lp) ?
                                  lg_wait_after_reset_p : phase_bits_lp;

  // slave reset sits two flops behind the counter, so the wait ends two early
  localparam logic [count_width_lp-1:0] wait_last_lp =
    count_width_lp'(2 ** lg_wait_after_reset_p - 2);
  localparam logic [count_width_lp-1:0] prepare_last_lp =
    count_width_lp'(prepare_cycles_p - 1);
  localparam logic [count_width_lp-1:0] hold_last_lp =
    count_width_lp'(hold_cycles_p - 1);
  localparam link_pkg::test_index_t last_test_lp =
    link_pkg::test_index_t'(link_pkg::number_tests_c - 1);

  link_pkg::calib_state_e state_r, state_n;
  logic [count_width_lp-1:0] count_r, count_n;
  link_pkg::test_index_t test_r, test_n;

  logic slave_reset_r;
  logic calib_hold_r;
  logic sample_r;
  logic calib_done_r;

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb begin
    state_n = state_r;
    count_n = count_r + 1'b1;
    test_n = test_r;
    unique case (state_r)
      link_pkg::calib_wait_s: begin
        if (count_r == wait_last_lp) begin
          state_n = link_pkg::calib_prepare_s;
          count_n = '0;
        end
      end
      link_pkg::calib_prepare_s: begin
        // index steps on entry to hold, it stays valid through the sample
        if (count_r == prepare_last_lp) begin
          state_n = link_pkg::calib_hold_s;
          count_n = '0;
          test_n = test_r + 1'b1;
        end
      end
      link_pkg::calib_hold_s: begin
        if (count_r == hold_last_lp) begin
          count_n = '0;
          if (test_r == last_test_lp) begin
            state_n = link_pkg::calib_done_s;
          end else begin
            state_n = link_pkg::calib_prepare_s;
          end
        end
      end
      default: begin
        // done is terminal until reset
        count_n = count_r;
      end
    endcase
  end

  // ----------------------------------------
  // state and phase registers
  // ----------------------------------------

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      state_r <= link_pkg::calib_wait_s;
      count_r <= '0;
      // all ones so the first hold wraps it to test 0
      test_r <= '1;
      slave_reset_r <= 1'b0;
      calib_hold_r <= 1'b0;
      sample_r <= 1'b0;
      calib_done_r <= 1'b0;
    end else begin
      state_r <= state_n;
      count_r <= count_n;
      test_r <= test_n;
      // hold leads the line by one, the channel output adds the other flop
      calib_hold_r <= (state_n == link_pkg::calib_hold_s);
      // these three are aligned with the line, one behind the state
      slave_reset_r <= (state_r == link_pkg::calib_prepare_s);
      sample_r <= (state_r == link_pkg::calib_hold_s) && (count_r == hold_last_lp);
      calib_done_r <= (state_r == link_pkg::calib_done_s);
    end
  end

  assign slave_reset_o = slave_reset_r;
  assign calib_hold_o = calib_hold_r;
  assign sample_o = sample_r;
  assign calib_done_o = calib_done_r;
  assign test_index_o = test_r;

endmodule

/* src/link_channel_out.sv */
// one outgoing channel, calibration code during hold and core words once active
// line outputs are registered, so data mode has one cycle of latency

module link_channel_out #(
  parameter int channel_width_p = 8,
  parameter int lg_start_credits_p = 3,
  parameter int lg_token_decimation_p = 1
) (
  input  logic                       io_master_clk_i,
  input  logic                       reset_i,
  input  logic                       calib_hold_i,
  input  logic                       channel_active_i,
  input  logic                       core_valid_i,
  input  logic                       token_i,
  input  logic [channel_width_p-1:0] core_data_i,
  input  link_pkg::test_index_t      test_index_i,
  output logic                       core_ready_o,
  output logic                       im_valid_tline_o,
  output logic [channel_width_p-1:0] im_data_tline_o
);

  logic credit_avail_w;
  logic send_w;
  link_pkg::calib_word_u code_w;
  link_pkg::calib_word_u data_w;
  link_pkg::calib_word_u line_w;
  logic valid_r;
  logic [channel_width_p-1:0] data_r;

  // ----------------------------------------
  // flow control
  // ----------------------------------------

  // ready comes from registers only
  assign core_ready_o = channel_active_i && credit_avail_w;
  assign send_w = core_valid_i && core_ready_o;

  link_credit_counter #(
    .lg_start_credits_p(lg_start_credits_p),
    .lg_token_decimation_p(lg_token_decimation_p)
  ) credit_i (
    .io_master_clk_i(io_master_clk_i),
    .reset_i(reset_i),
    .send_i(send_w),
    .token_i(token_i),
    .credit_avail_o(credit_avail_w)
  );

  // ----------------------------------------
  // line word select
  // ----------------------------------------

  always_comb begin
    code_w.calib_view.valid = 1'b1;
    code_w.calib_view.tag = test_index_i;
    code_w.calib_view.pattern = test_index_i[0] ? link_pkg::calib_pattern_odd_c :
                                                  link_pkg::calib_pattern_even_c;
    data_w.data_view.valid = send_w;
    data_w.data_view.data = core_data_i;
    // hold and active never overlap, active comes after the last test
    line_w = calib_hold_i ? code_w : data_w;
  end

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= line_w.data_view.valid;
    end
  end

  // data holds its last value while the line is idle
  always_ff @(posedge io_master_clk_i) begin
    if (line_w.data_view.valid) begin
      data_r <= line_w.data_view.data;
    end
  end

  assign im_valid_tline_o = valid_r;
  assign im_data_tline_o = data_r;

endmodule

/* src/link_credit_counter.sv */
// saturating credit count for one channel, starts full after reset
// requires lg_token_decimation_p <= lg_start_credits_p

module link_credit_counter #(
  parameter int lg_start_credits_p = 3,
  parameter int lg_token_decimation_p = 1
) (
  input  logic io_master_clk_i,
  input  logic reset_i,
  input  logic send_i,
  input  logic token_i,
  output logic credit_avail_o
);

  // one spare bit so full plus a token refill does not wrap
  localparam int count_width_lp = lg_start_credits_p + 2;
  localparam logic [count_width_lp-1:0] max_credits_lp =
    count_width_lp'(2 ** lg_start_credits_p);
  localparam logic [count_width_lp-1:0] token_credits_lp =
    count_width_lp'(2 ** lg_token_decimation_p);

  logic [count_width_lp-1:0] count_r;
  logic [count_width_lp-1:0] refill_w;
  logic [count_width_lp-1:0] sum_w;
  logic [count_width_lp-1:0] count_n;

  // ----------------------------------------
  // update
  // ----------------------------------------

  // each token stands for a decimated group of consumed words
  assign refill_w = token_i ? token_credits_lp : '0;

  // send only happens with credit left, so no underflow
  assign sum_w = count_r + refill_w - {{(count_width_lp - 1){1'b0}}, send_i};

  // far side never owes more than the start amount
  assign count_n = (sum_w > max_credits_lp) ? max_credits_lp : sum_w;

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      count_r <= max_credits_lp;
    end else begin
      count_r <= count_n;
    end
  end

  assign credit_avail_o = (count_r != '0);

endmodule

/* src/link_master_kernel.sv */
// single-clock master link kernel, calibrates each channel then carries core words
// channel_width_p is fixed by the line word in link_pkg

module link_master_kernel #(
  parameter int channel_width_p = 8,
  parameter int link_channels_p = 2,
  parameter int lg_wait_after_reset_p = 4,
  parameter int prepare_cycles_p = 6,
  parameter int hold_cycles_p = 4,
  parameter int lg_start_credits_p = 3,
  parameter int lg_token_decimation_p = 1
) (
  input  logic                       io_master_clk_i,
  input  logic                       reset_i,
  input  logic [link_channels_p-1:0] core_valid_i,
  input  logic [channel_width_p-1:0] core_data_i [link_channels_p],
  output logic [link_channels_p-1:0] core_ready_o,
  output logic [link_channels_p-1:0] core_active_channels_o,
  input  logic [link_channels_p-1:0] token_i,
  input  logic [link_channels_p-1:0] io_valid_i,
  input  logic [channel_width_p-1:0] io_data_i [link_channels_p],
  output logic [link_channels_p-1:0] im_valid_tline_o,
  output logic [channel_width_p-1:0] im_data_tline_o [link_channels_p],
  output logic                       im_slave_reset_tline_o,
  output logic                       calib_done_o
);

  if (channel_width_p != link_pkg::channel_width_c) begin : g_width_check
    $error("channel_width_p must equal link_pkg::channel_width_c");
  end

  // sequencer outputs shared by all channels
  link_pkg::test_index_t test_index;
  logic calib_hold;
  logic sample;
  logic calib_done;

  link_pkg::calib_word_u io_word [link_channels_p];

  link_calib_sequencer #(
    .lg_wait_after_reset_p(lg_wait_after_reset_p),
    .prepare_cycles_p(prepare_cycles_p),
    .hold_cycles_p(hold_cycles_p)
  ) seq_i (
    .io_master_clk_i(io_master_clk_i),
    .reset_i(reset_i),
    .slave_reset_o(im_slave_reset_tline_o),
    .calib_hold_o(calib_hold),
    .sample_o(sample),
    .calib_done_o(calib_done),
    .test_index_o(test_index)
  );

  assign calib_done_o = calib_done;

  // ----------------------------------------
  // per-channel checker and output
  // ----------------------------------------

  for (genvar ch = 0; ch < link_channels_p; ch++) begin : g_ch
    // returned line packed as a data word, the checker reads it as a code
    assign io_word[ch].data_view.valid = io_valid_i[ch];
    assign io_word[ch].data_view.data = io_data_i[ch];

    link_calib_checker checker_i (
      .io_master_clk_i(io_master_clk_i),
      .reset_i(reset_i),
      .sample_i(sample),
      .calib_done_i(calib_done),
      .io_valid_i(io_valid_i[ch]),
      .io_word_i(io_word[ch]),
      .test_index_i(test_index),
      .channel_active_o(core_active_channels_o[ch])
    );

    link_channel_out #(
      .channel_width_p(channel_width_p),
      .lg_start_credits_p(lg_start_credits_p),
      .lg_token_decimation_p(lg_token_decimation_p)
    ) out_i (
      .io_master_clk_i(io_master_clk_i),
      .reset_i(reset_i),
      .calib_hold_i(calib_hold),
      .channel_active_i(core_active_channels_o[ch]),
      .core_valid_i(core_valid_i[ch]),
      .token_i(token_i[ch]),
      .core_data_i(core_data_i[ch]),
      .test_index_i(test_index),
      .core_ready_o(core_ready_o[ch]),
      .im_valid_tline_o(im_valid_tline_o[ch]),
      .im_data_tline_o(im_data_tline_o[ch])
    );
  end

endmodule

/* src/link_pkg.sv */
// shared sizes and types for the master link kernel
// the line word is fixed at valid plus 8 data bits, so channel_width_p must be 8

package link_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // data bits per line word, the top level checks channel_width_p against it
  localparam int channel_width_c = 8;

  // calibration tests run per channel before activation
  localparam int number_tests_c = 3;

  // test tag width inside the calibration view
  localparam int test_index_width_c = 2;

  // pattern bits left after valid and tag
  localparam int calib_pattern_width_c = channel_width_c - test_index_width_c;

  typedef logic [test_index_width_c-1:0] test_index_t;

  // patterns alternate per test so a stuck line cannot pass two tests in a row
  localparam logic [calib_pattern_width_c-1:0] calib_pattern_even_c = 6'b101010;
  localparam logic [calib_pattern_width_c-1:0] calib_pattern_odd_c = 6'b010101;

  // ----------------------------------------
  // sequencer phases
  // ----------------------------------------

  typedef enum logic [1:0] {
    calib_wait_s,
    calib_prepare_s,
    calib_hold_s,
    calib_done_s
  } calib_state_e;

  // ----------------------------------------
  // line word
  // ----------------------------------------

  // normal traffic, valid plus one core word
  typedef struct packed {
    logic valid;
    logic [channel_width_c-1:0] data;
  } data_view_t;

  // calibration code, tag carries the test index
  typedef struct packed {
    logic valid;
    test_index_t tag;
    logic [calib_pattern_width_c-1:0] pattern;
  } calib_view_t;

  // same 9 bits on the wire, read as data or as calibration code
  typedef union packed {
    data_view_t data_view;
    calib_view_t calib_view;
  } calib_word_u;

endpackage

/* verification/link_master_kernel_asserts.sv */
// concurrent checks on the kernel top level, bound from the testbench
// sequencer state is taken from the seq_i instance inside the kernel

module link_master_kernel_asserts #(
  parameter int link_channels_p = 2
) (
  input logic                       io_master_clk_i,
  input logic                       reset_i,
  input logic [link_channels_p-1:0] core_valid_i,
  input logic [link_channels_p-1:0] core_ready_o,
  input logic [link_channels_p-1:0] core_active_channels_o,
  input logic [link_channels_p-1:0] im_valid_tline_o,
  input logic                       im_slave_reset_tline_o,
  input logic                       calib_done_o,
  input link_pkg::calib_state_e     seq_state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // number of failed assertions
  int fail_count = 0;

  // ready only on an active channel
  ready_needs_active_a: assert property (@(posedge io_master_clk_i)
    disable iff (reset_i)
    (core_ready_o & ~core_active_channels_o) == '0)
    else begin
      fail_count++;
      $error("core ready raised on an inactive channel");
    end

  // in data mode the line shows exactly last cycle's accepts
  data_valid_follows_accept_a: assert property (@(posedge io_master_clk_i)
    disable iff (reset_i)
    calib_done_o |-> (im_valid_tline_o == $past(core_valid_i & core_ready_o)))
    else begin
      fail_count++;
      $error("line valid does not follow an accept by one cycle");
    end

  // slave reset and calibration code are separate phases
  reset_hold_apart_a: assert property (@(posedge io_master_clk_i)
    disable iff (reset_i)
    !(im_slave_reset_tline_o && (|im_valid_tline_o)))
    else begin
      fail_count++;
      $error("slave reset overlaps a valid line word");
    end

  done_sticky_a: assert property (@(posedge io_master_clk_i)
    disable iff (reset_i) calib_done_o |=> calib_done_o)
    else begin
      fail_count++;
      $error("calib_done fell without reset");
    end

  // nothing leaves the kernel while it waits after reset
  wait_quiet_a: assert property (@(posedge io_master_clk_i)
    disable iff (reset_i)
    (seq_state_i == link_pkg::calib_wait_s) |->
      (!im_slave_reset_tline_o && (im_valid_tline_o == '0) && (core_ready_o == '0)))
    else begin
      fail_count++;
      $error("line or ready active during the wait after reset");
    end

endmodule

/* verification/link_master_kernel_tb.sv */
// random traffic on channel 0 against a credit model, far side loops lines back
// channel 1 gets a data fault in test 1 so it must stay inactive

module link_master_kernel_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int chans_lp = 2;
  localparam int wait_cycles_lp = 16;
  localparam int prepare_lp = 6;
  localparam int max_credits_lp = 8;
  localparam int token_credits_lp = 2;

  logic io_master_clk_i;
  logic reset_i;
  logic [chans_lp-1:0] core_valid_i, token_i, io_valid_i;
  logic [7:0] core_data_i [chans_lp];
  logic [7:0] io_data_i [chans_lp];
  logic [chans_lp-1:0] core_ready_o, core_active_channels_o, im_valid_tline_o;
  logic [7:0] im_data_tline_o [chans_lp];
  logic im_slave_reset_tline_o, calib_done_o;

  int errors = 0;
  int checks = 0;
  logic [31:0] lcg_state = 32'h11b3_1634;

  // far side and credit model state
  int cyc = 0;
  int cal_test = -1;
  int credits = max_credits_lp;
  int rx_count = 0;
  int sent_total = 0;
  int recv_total = 0;
  int burst_count = 0;
  bit traffic_en = 0;
  bit force_valid = 0;
  bit withhold = 0;
  logic sr_prev_p = 0;
  logic sent_prev = 0;
  logic [7:0] exp_q [$];
  int due_q [$];

  // negedge monitor state
  int post_cyc = 0;
  int pulses = 0;
  int sr_len = 0;
  logic sr_prev = 0;
  logic done_prev = 0;

  link_master_kernel dut_i (.*);

  bind link_master_kernel link_master_kernel_asserts #(
    .link_channels_p(link_channels_p)
  ) asserts_i (
    .io_master_clk_i(io_master_clk_i),
    .reset_i(reset_i),
    .core_valid_i(core_valid_i),
    .core_ready_o(core_ready_o),
    .core_active_channels_o(core_active_channels_o),
    .im_valid_tline_o(im_valid_tline_o),
    .im_slave_reset_tline_o(im_slave_reset_tline_o),
    .calib_done_o(calib_done_o),
    .seq_state_i(seq_i.state_r)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic verify_quiet(string name);
    check_equal({name, " valid"}, 0, im_valid_tline_o);
    check_equal({name, " ready"}, 0, core_ready_o);
    check_equal({name, " slave reset"}, 0, im_slave_reset_tline_o);
    check_equal({name, " done"}, 0, calib_done_o);
    check_equal({name, " active"}, 0, core_active_channels_o);
  endtask

  // words or tokens still in flight on channel 0
  function automatic bit traffic_pending();
    return core_valid_i[0] || token_i[0] || (exp_q.size() > 0) || (due_q.size() > 0);
  endfunction

  initial begin
    io_master_clk_i = 0;
    forever #50 io_master_clk_i = ~io_master_clk_i;
  end

  // ----------------------------------------
  // far side, credit model and drivers
  // ----------------------------------------

  always @(posedge io_master_clk_i) begin
    logic send;
    logic pred;
    logic [31:0] rnd;
    cyc++;
    if (im_slave_reset_tline_o && !sr_prev_p) cal_test++;
    sr_prev_p <= im_slave_reset_tline_o;
    // loopback with one register, bit 0 of channel 1 flipped in test 1
    io_valid_i <= im_valid_tline_o;
    io_data_i[0] <= im_data_tline_o[0];
    io_data_i[1] <= im_data_tline_o[1] ^ {7'd0, (cal_test == 1) && !calib_done_o};
    if (reset_i) begin
      credits = max_credits_lp;
      sent_prev = 0;
    end else begin
      pred = calib_done_o && (credits > 0);
      check_equal("ready ch0", pred, core_ready_o[0]);
      send = core_valid_i[0] && pred;
      if (send) begin
        exp_q.push_back(core_data_i[0]);
        sent_total++;
        if (withhold) burst_count++;
      end
      credits = credits - send + (token_i[0] ? token_credits_lp : 0);
      if (credits > max_credits_lp) credits = max_credits_lp;
      // an accepted word is on the line exactly one cycle later
      if (calib_done_o) check_equal("line valid ch0", sent_prev, im_valid_tline_o[0]);
      if (calib_done_o && im_valid_tline_o[0]) begin
        recv_total++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("line word %0h on channel 0 with no word accepted", im_data_tline_o[0]);
        end else begin
          check_equal("line data ch0", exp_q.pop_front(), im_data_tline_o[0]);
        end
        rx_count++;
        if (rx_count % 2 == 0) due_q.push_back(cyc + int'(next_rand() % 8));
      end
      sent_prev = send;
      // one token pulse per cycle at most
      if (!withhold && due_q.size() > 0 && due_q[0] <= cyc) begin
        token_i[0] <= 1'b1;
        void'(due_q.pop_front());
      end else begin
        token_i[0] <= 1'b0;
      end
      // core holds an unaccepted word
      if (!(core_valid_i[0] && !send)) begin
        rnd = next_rand();
        core_data_i[0] <= rnd[15:8];
        core_valid_i[0] <= traffic_en && (force_valid || rnd[16]);
      end
      rnd = next_rand();
      core_valid_i[1] <= rnd[16];
      core_data_i[1] <= rnd[15:8];
    end
  end

  // ----------------------------------------
  // output checks at the falling edge
  // ----------------------------------------

  always @(negedge io_master_clk_i) begin
    logic [7:0] code;
    if (reset_i) begin
      post_cyc = 0;
      verify_quiet("reset");
    end else begin
      if (im_slave_reset_tline_o && !sr_prev) begin
        pulses++;
        sr_len = 0;
        if (pulses == 1) check_equal("slave reset start", wait_cycles_lp, post_cyc);
      end
      if (im_slave_reset_tline_o) sr_len++;
      if (!im_slave_reset_tline_o && sr_prev) check_equal("slave reset len", prepare_lp, sr_len);
      if (post_cyc < wait_cycles_lp) verify_quiet("wait");
      // calibration view: tag then alternating pattern
      code = {2'(pulses - 1), ((pulses - 1) % 2 == 1) ? 6'b010101 : 6'b101010};
      for (int ch = 0; ch < chans_lp; ch++) begin
        if (!calib_done_o && im_valid_tline_o[ch]) begin
          check_equal("calib word", code, im_data_tline_o[ch]);
        end
      end
      if (calib_done_o && !done_prev) begin
        check_equal("test count", 3, pulses);
        check_equal("active channels", 2'b01, core_active_channels_o);
      end
      if (calib_done_o) begin
        check_equal("ready ch1", 0, core_ready_o[1]);
        check_equal("valid ch1", 0, im_valid_tline_o[1]);
      end
      sr_prev = im_slave_reset_tline_o;
      done_prev = calib_done_o;
      post_cyc++;
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  task automatic run_sequence();
    int n;
    int start_credits;
    n = 0;
    while (!calib_done_o && n < 500) begin
      @(negedge io_master_clk_i);
      n++;
    end
    if (!calib_done_o) begin
      report_timeout("calib_done");
      return;
    end
    traffic_en = 1;
    repeat (300) @(negedge io_master_clk_i);
    // drain, then run into zero credits with tokens held back
    traffic_en = 0;
    n = 0;
    while (traffic_pending() && n < 200) begin
      @(negedge io_master_clk_i);
      n++;
    end
    if (traffic_pending()) begin
      report_timeout("traffic drain");
      return;
    end
    withhold = 1;
    start_credits = credits;
    force_valid = 1;
    traffic_en = 1;
    n = 0;
    @(negedge io_master_clk_i);
    while (core_ready_o[0] && n < 100) begin
      @(negedge io_master_clk_i);
      n++;
    end
    if (core_ready_o[0]) begin
      report_timeout("ready to fall");
      return;
    end
    repeat (10) @(negedge io_master_clk_i);
    check_equal("burst words", start_credits, burst_count);
    withhold = 0;
    force_valid = 0;
    traffic_en = 0;
    n = 0;
    while (traffic_pending() && n < 300) begin
      @(negedge io_master_clk_i);
      n++;
    end
    if (traffic_pending()) begin
      report_timeout("final drain");
      return;
    end
    check_equal("words sent vs received", sent_total, recv_total);
  endtask

  initial begin
    reset_i = 1;
    core_valid_i = '0;
    token_i = '0;
    io_valid_i = '0;
    core_data_i = '{default: '0};
    io_data_i = '{default: '0};
    repeat (8) @(posedge io_master_clk_i);
    reset_i <= 0;
    run_sequence();
    errors += dut_i.asserts_i.fail_count;
    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
